/* hdl/pipePkg.sv */
/* Shared widths and types for the pipelined back end.
   Every RTL file imports what it needs from here. */
`default_nettype none

package pipePkg;

  ////////////////////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////////////////////
  parameter int regIdBits   = 4;   // Sixteen architectural registers
  parameter int dataBits    = 16;  // Width of the datapath word
  parameter int numRegs     = 2 ** regIdBits;
  parameter int memAddrBits = 8;   // Data memory holds 256 words

  typedef logic [regIdBits-1:0] regIdT;  // Register id
  typedef logic [dataBits-1:0]  dataT;   // Datapath word

  ////////////////////////////////////////////////////////////////////////////
  // Encodings
  ////////////////////////////////////////////////////////////////////////////
  // Loads and stores both form their address as rs1 plus the immediate
  typedef enum logic [2:0] {
    opAdd   = 3'd0,
    opSub   = 3'd1,
    opAnd   = 3'd2,
    opXor   = 3'd3,
    opSll   = 3'd4,  // Shift amount is the low four bits of operand B
    opSrl   = 3'd5,
    opLoad  = 3'd6,
    opStore = 3'd7   // Stores take their data from rs2
  } aluOpT;

  // Operand source chosen by the forwarding unit
  typedef enum logic [1:0] {
    fwdNone  = 2'b00,  // Value read from the register file
    fwdMemWb = 2'b01,  // Result held in the MEM/WB register
    fwdExMem = 2'b10   // Result held in the EX/MEM register
  } fwdSelT;

endpackage : pipePkg

`default_nettype wire

/* hdl/stageBus.sv */
/* One pipeline register bundle between two stages.
   The stage that owns the register takes producer, every reader takes consumer. */
`default_nettype none

interface stageBus;
  import pipePkg::*;

  logic  valid;      // An instruction occupies this stage
  logic  regWrite;   // Instruction writes rd at write-back
  regIdT rd;         // Destination register
  regIdT src2;       // Second source id, needed for store data forwarding
  dataT  result;     // ALU result, load data or memory address
  dataT  storeData;  // Data a store puts into memory
  logic  memRead;    // Instruction is a load
  logic  memWrite;   // Instruction is a store

  // Owning stage drives all fields from its pipeline register
  modport producer (
    output valid,
    output regWrite,
    output rd,
    output src2,
    output result,
    output storeData,
    output memRead,
    output memWrite
  );

  // Downstream stages, the forwarding unit and the register file only look
  modport consumer (
    input valid,
    input regWrite,
    input rd,
    input src2,
    input result,
    input storeData,
    input memRead,
    input memWrite
  );

endinterface : stageBus

`default_nettype wire

/* hdl/regFile.sv */
/* Sixteen-entry register file with two combinational read ports.
   Write-back comes from the MEM/WB bundle and is visible to reads in the same cycle. */
`default_nettype none

module regFile (
  input  wire           clk,
  input  wire           rst,
  input  pipePkg::regIdT rdAddr1,  // Read address for operand A
  input  pipePkg::regIdT rdAddr2,  // Read address for operand B or store data
  output pipePkg::dataT  rdData1,
  output pipePkg::dataT  rdData2,
  stageBus.consumer      wb        // MEM/WB bundle carrying the write-back
);
  import pipePkg::*;

  dataT regs [numRegs];  // Entry 0 is never written
  logic wbEn;            // Qualified write strobe

  // Register 0 is never a destination
  assign wbEn = wb.valid & wb.regWrite & (wb.rd != '0);

  // Registers start architecturally at zero
  always_ff @(posedge clk) begin
    if (rst) begin
      regs <= '{default: '0};
    end else if (wbEn) begin
      regs[wb.rd] <= wb.result;
    end
  end

  // Write-through so an instruction issued while an older one is in
  // write-back sees the new value
  always_comb begin
    if (rdAddr1 == '0)                  rdData1 = '0;
    else if (wbEn && wb.rd == rdAddr1) rdData1 = wb.result;  // Bypass
    else                               rdData1 = regs[rdAddr1];
  end

  always_comb begin
    if (rdAddr2 == '0)                  rdData2 = '0;
    else if (wbEn && wb.rd == rdAddr2) rdData2 = wb.result;  // Bypass
    else                               rdData2 = regs[rdAddr2];
  end

endmodule : regFile

`default_nettype wire

/* hdl/forwardingUnit.sv */
/* Combinational forwarding selects for the ALU operands and the store data.
   Compares the ID/EX source ids against the destinations held in EX/MEM and MEM/WB. */
`default_nettype none

module forwardingUnit (
  input  pipePkg::regIdT  idExSrc1,     // First source of the instruction in EX
  input  pipePkg::regIdT  idExSrc2,     // Second source of the instruction in EX
  stageBus.consumer       exMem,        // Instruction one ahead
  stageBus.consumer       memWb,        // Instruction two ahead
  output pipePkg::fwdSelT fwdA,         // Select for ALU operand A
  output pipePkg::fwdSelT fwdB,         // Select for ALU operand B
  output logic            fwdStoreEx,   // Store in EX takes MEM/WB data
  output logic            fwdStoreMem   // Store in MEM takes MEM/WB data
);
  import pipePkg::*;

  logic exMemWrites;  // EX/MEM holds a live register writer
  logic memWbWrites;  // MEM/WB holds a live register writer
  logic exHazA;       // Operand A depends on the instruction one ahead
  logic exHazB;       // Operand B depends on the instruction one ahead
  logic memHazA;      // Operand A depends on the instruction two ahead
  logic memHazB;      // Operand B depends on the instruction two ahead

  ////////////////////////////////////////////////////////////////////////////
  // Writer qualification
  ////////////////////////////////////////////////////////////////////////////
  // Register 0 is constant so a writer to it never forwards
  assign exMemWrites = exMem.valid & exMem.regWrite & (exMem.rd != '0);
  assign memWbWrites = memWb.valid & memWb.regWrite & (memWb.rd != '0);

  ////////////////////////////////////////////////////////////////////////////
  // ALU operand hazards
  ////////////////////////////////////////////////////////////////////////////
  assign exHazA  = exMemWrites & (exMem.rd == idExSrc1);
  assign exHazB  = exMemWrites & (exMem.rd == idExSrc2);
  assign memHazA = memWbWrites & (memWb.rd == idExSrc1);
  assign memHazB = memWbWrites & (memWb.rd == idExSrc2);

  // The newer result in EX/MEM wins when both stages write the same register
  assign fwdA = exHazA  ? fwdExMem :
                memHazA ? fwdMemWb : fwdNone;

  assign fwdB = exHazB  ? fwdExMem :
                memHazB ? fwdMemWb : fwdNone;

  ////////////////////////////////////////////////////////////////////////////
  // Store data hazards
  ////////////////////////////////////////////////////////////////////////////
  // A match against EX/MEM is left alone here, since that writer reaches
  // MEM/WB just as the store reaches MEM and is caught below
  assign fwdStoreEx = memWbWrites & (memWb.rd == idExSrc2);

  // Store in MEM whose data register is written by the instruction in WB
  assign fwdStoreMem = memWbWrites & (memWb.rd == exMem.src2);

endmodule : forwardingUnit

`default_nettype wire

/* hdl/executeStage.sv */
/* ID/EX pipeline register, forwarding operand muxes and the ALU.
   Loads the issued instruction on the issue edge and drives the EX/MEM bundle. */
`default_nettype none

module executeStage (
  input  wire             clk,
  input  wire             rst,
  input  wire             issueValid,   // Instruction presented this cycle
  input  pipePkg::aluOpT  issueOp,
  input  pipePkg::regIdT  issueRs1,
  input  pipePkg::regIdT  issueRs2,
  input  pipePkg::regIdT  issueRd,
  input  pipePkg::dataT   issueImm,
  input  pipePkg::dataT   rfData1,      // Register file read of issueRs1
  input  pipePkg::dataT   rfData2,      // Register file read of issueRs2
  input  pipePkg::fwdSelT fwdA,
  input  pipePkg::fwdSelT fwdB,
  input  wire             fwdStoreEx,
  output pipePkg::regIdT  idExSrc1,     // Source ids for the forwarding unit
  output pipePkg::regIdT  idExSrc2,
  stageBus.consumer       memWb,        // Older result for forwarding
  stageBus.producer       exMem         // EX/MEM register
);
  import pipePkg::*;

  // ID/EX register
  logic  idExValid;
  aluOpT idExOp;
  regIdT idExRs1;
  regIdT idExRs2;
  regIdT idExRd;
  dataT  idExImm;
  dataT  idExVal1;  // Register values read in the issue cycle
  dataT  idExVal2;

  dataT  srcA;      // Operand A after forwarding
  dataT  srcB;      // Register operand B after forwarding
  dataT  opB;       // ALU operand B, immediate for memory ops
  dataT  aluOut;
  dataT  storeVal;  // Store data after forwarding from MEM/WB
  logic  isMemOp;

  ////////////////////////////////////////////////////////////////////////////
  // ID/EX register
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (rst) idExValid <= 1'b0;
    else     idExValid <= issueValid;
  end

  always_ff @(posedge clk) begin
    idExOp   <= issueOp;
    idExRs1  <= issueRs1;
    idExRs2  <= issueRs2;
    idExRd   <= issueRd;
    idExImm  <= issueImm;
    idExVal1 <= rfData1;
    idExVal2 <= rfData2;
  end

  assign idExSrc1 = idExRs1;
  assign idExSrc2 = idExRs2;

  ////////////////////////////////////////////////////////////////////////////
  // Operand selection and ALU
  ////////////////////////////////////////////////////////////////////////////
  always_comb begin
    case (fwdA)
      fwdExMem: srcA = exMem.result;  // Result of the instruction one ahead
      fwdMemWb: srcA = memWb.result;  // Result of the instruction two ahead
      default:  srcA = idExVal1;
    endcase
    case (fwdB)
      fwdExMem: srcB = exMem.result;
      fwdMemWb: srcB = memWb.result;
      default:  srcB = idExVal2;
    endcase
  end

  assign isMemOp = (idExOp == opLoad) || (idExOp == opStore);
  assign opB     = isMemOp ? idExImm : srcB;

  // A newer writer still in EX/MEM is picked up later in the memory stage
  assign storeVal = fwdStoreEx ? memWb.result : idExVal2;

  always_comb begin
    case (idExOp)
      opAdd:   aluOut = srcA + opB;
      opSub:   aluOut = srcA - opB;
      opAnd:   aluOut = srcA & opB;
      opXor:   aluOut = srcA ^ opB;
      opSll:   aluOut = srcA << opB[3:0];
      opSrl:   aluOut = srcA >> opB[3:0];
      default: aluOut = srcA + opB;  // Address for loads and stores
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // EX/MEM register
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      exMem.valid    <= 1'b0;
      exMem.regWrite <= 1'b0;
      exMem.memRead  <= 1'b0;
      exMem.memWrite <= 1'b0;
    end else begin
      exMem.valid    <= idExValid;
      exMem.regWrite <= idExOp != opStore;  // Every op except a store writes rd
      exMem.memRead  <= idExOp == opLoad;
      exMem.memWrite <= idExOp == opStore;
    end
  end

  always_ff @(posedge clk) begin
    exMem.rd        <= idExRd;
    exMem.src2      <= idExRs2;
    exMem.result    <= aluOut;
    exMem.storeData <= storeVal;
  end

endmodule : executeStage

`default_nettype wire

/* hdl/memoryStage.sv */
/* Data memory access and the MEM/WB pipeline register.
   Stores write on the edge that leaves MEM, loads read combinationally into MEM/WB. */
`default_nettype none

module memoryStage #(
  parameter int memAddrBits = pipePkg::memAddrBits  // Word address width
) (
  input  wire       clk,
  input  wire       rst,
  input  wire       fwdStoreMem,  // Replace store data with the MEM/WB result
  stageBus.consumer exMem,        // Instruction in the memory stage
  stageBus.producer memWb         // MEM/WB register
);
  import pipePkg::*;

  dataT mem [2 ** memAddrBits];  // Word-addressed data memory

  logic [memAddrBits-1:0] addr;
  dataT                   storeVal;  // Store data after MEM-to-MEM forwarding
  dataT                   loadVal;

  // Only the low address bits select a word
  assign addr = exMem.result[memAddrBits-1:0];

  // The writer just ahead of a store is in MEM/WB now and is the newest copy
  assign storeVal = fwdStoreMem ? memWb.result : exMem.storeData;

  assign loadVal = mem[addr];

  ////////////////////////////////////////////////////////////////////////////
  // Data memory
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (exMem.valid && exMem.memWrite) begin
      mem[addr] <= storeVal;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // MEM/WB register
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      memWb.valid    <= 1'b0;
      memWb.regWrite <= 1'b0;
      memWb.memRead  <= 1'b0;
      memWb.memWrite <= 1'b0;
    end else begin
      memWb.valid    <= exMem.valid;
      memWb.regWrite <= exMem.regWrite;
      memWb.memRead  <= exMem.memRead;
      memWb.memWrite <= exMem.memWrite;
    end
  end

  always_ff @(posedge clk) begin
    memWb.rd        <= exMem.rd;
    memWb.src2      <= exMem.src2;
    memWb.result    <= exMem.memRead ? loadVal : exMem.result;  // Load data or ALU result
    memWb.storeData <= storeVal;  // Data actually stored, kept for observation
  end

endmodule : memoryStage

`default_nettype wire

/* hdl/pipeBackEnd.sv */
/* Top level of the pipelined back end.
   Takes one decoded instruction per cycle and reports each write-back two cycles later. */
`default_nettype none

module pipeBackEnd #(
  parameter int memAddrBits = pipePkg::memAddrBits  // Passed down to the data memory
) (
  input  wire            clk,
  input  wire            rst,
  input  wire            issueValid,  // One decoded instruction this cycle
  input  pipePkg::aluOpT issueOp,
  input  pipePkg::regIdT issueRs1,
  input  pipePkg::regIdT issueRs2,
  input  pipePkg::regIdT issueRd,
  input  pipePkg::dataT  issueImm,
  output logic           wbValid,     // Instruction leaving the pipe
  output pipePkg::regIdT wbRd,
  output pipePkg::dataT  wbData
);
  import pipePkg::*;

  dataT   rfData1;
  dataT   rfData2;
  regIdT  idExSrc1;
  regIdT  idExSrc2;
  fwdSelT fwdA;
  fwdSelT fwdB;
  logic   fwdStoreEx;
  logic   fwdStoreMem;

  stageBus exMemBus ();  // Between execute and memory
  stageBus memWbBus ();  // Between memory and write-back

  ////////////////////////////////////////////////////////////////////////////
  // Register read and forwarding
  ////////////////////////////////////////////////////////////////////////////
  regFile uRegFile (
    .clk     (clk),
    .rst     (rst),
    .rdAddr1 (issueRs1),  // Read in the issue cycle
    .rdAddr2 (issueRs2),
    .rdData1 (rfData1),
    .rdData2 (rfData2),
    .wb      (memWbBus.consumer)
  );

  forwardingUnit uForwardingUnit (
    .idExSrc1    (idExSrc1),
    .idExSrc2    (idExSrc2),
    .exMem       (exMemBus.consumer),
    .memWb       (memWbBus.consumer),
    .fwdA        (fwdA),
    .fwdB        (fwdB),
    .fwdStoreEx  (fwdStoreEx),
    .fwdStoreMem (fwdStoreMem)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Execute and memory stages
  ////////////////////////////////////////////////////////////////////////////
  executeStage uExecuteStage (
    .clk        (clk),
    .rst        (rst),
    .issueValid (issueValid),
    .issueOp    (issueOp),
    .issueRs1   (issueRs1),
    .issueRs2   (issueRs2),
    .issueRd    (issueRd),
    .issueImm   (issueImm),
    .rfData1    (rfData1),
    .rfData2    (rfData2),
    .fwdA       (fwdA),
    .fwdB       (fwdB),
    .fwdStoreEx (fwdStoreEx),
    .idExSrc1   (idExSrc1),
    .idExSrc2   (idExSrc2),
    .memWb      (memWbBus.consumer),
    .exMem      (exMemBus.producer)
  );

  memoryStage #(
    .memAddrBits (memAddrBits)
  ) uMemoryStage (
    .clk         (clk),
    .rst         (rst),
    .fwdStoreMem (fwdStoreMem),
    .exMem       (exMemBus.consumer),
    .memWb       (memWbBus.producer)
  );

  // Every instruction appears here, stores included, two cycles after issue
  assign wbValid = memWbBus.valid;
  assign wbRd    = memWbBus.rd;
  assign wbData  = memWbBus.result;

endmodule : pipeBackEnd

`default_nettype wire

/* tb/forwardChecker_checker.sv */
/* Assertions on the forwarding selects and the register 0 rules.
   Bound into the top level, where the clock and both stage bundles are visible. */
`default_nettype none

module forwardChecker (
  input wire             clk,
  input wire             rst,
  input wire             wbValid,
  input pipePkg::regIdT  idExSrc1,
  input pipePkg::regIdT  idExSrc2,
  input wire             exValid,
  input wire             exRegWrite,
  input pipePkg::regIdT  exRd,
  input pipePkg::regIdT  memWbRd,
  input pipePkg::fwdSelT fwdA,
  input pipePkg::fwdSelT fwdB,
  input wire             fwdStoreEx,
  input wire             fwdStoreMem
);
  timeunit 1ns;
  timeprecision 1ps;
  import pipePkg::*;

  logic exWrites;  // Live writer one ahead of EX
  assign exWrites = exValid && exRegWrite && (exRd != '0);

  // The instruction one ahead always wins an operand it writes
  exForwardA: assert property (@(posedge clk) disable iff (rst)
    exWrites && (exRd == idExSrc1) |-> fwdA == fwdExMem)
    else $error("EX/MEM writer of operand A was not forwarded");
  exForwardB: assert property (@(posedge clk) disable iff (rst)
    exWrites && (exRd == idExSrc2) |-> fwdB == fwdExMem)
    else $error("EX/MEM writer of operand B was not forwarded");

  ////////////////////////////////////////////////////////////////////////////
  // Register 0 and reset
  ////////////////////////////////////////////////////////////////////////////
  zeroExMem: assert property (@(posedge clk) disable iff (rst)
    (fwdA == fwdExMem || fwdB == fwdExMem) |-> exRd != '0)
    else $error("Forward from EX/MEM with destination register 0");
  zeroMemWb: assert property (@(posedge clk) disable iff (rst)
    (fwdA == fwdMemWb || fwdB == fwdMemWb || fwdStoreEx || fwdStoreMem) |-> memWbRd != '0)
    else $error("Forward from MEM/WB with destination register 0");
  quietReset: assert property (@(posedge clk) $past(rst) |-> !wbValid)
    else $error("Write-back valid while in reset");

endmodule : forwardChecker

bind pipeBackEnd forwardChecker uForwardChecker (
  .clk(clk), .rst(rst), .wbValid(wbValid), .idExSrc1(idExSrc1), .idExSrc2(idExSrc2),
  .exValid(exMemBus.valid), .exRegWrite(exMemBus.regWrite), .exRd(exMemBus.rd),
  .memWbRd(memWbBus.rd), .fwdA(fwdA), .fwdB(fwdB),
  .fwdStoreEx(fwdStoreEx), .fwdStoreMem(fwdStoreMem)
);

`default_nettype wire

/* tb/pipeBackEndTb.sv */
/* Testbench for the pipelined back end. Directed forwarding cases run first, then
   LFSR-driven random instructions, all checked against an in-order reference model. */
`default_nettype none

module pipeBackEndTb;
  timeunit 1ns;
  timeprecision 1ps;
  import pipePkg::*;

  localparam int clkPeriod   = 40;
  localparam int resetCycles = 16;
  localparam int numRandom   = 300;
  // Up to one bubble per random instruction, plus directed ops and drain
  localparam int runCycles   = resetCycles + 2 * numRandom + 100;

  logic  clk = 1'b0;
  logic  rst;
  logic  issueValid;
  aluOpT issueOp;
  regIdT issueRs1;
  regIdT issueRs2;
  regIdT issueRd;
  dataT  issueImm;
  logic  wbValid;
  regIdT wbRd;
  dataT  wbData;

  dataT        modelRegs [numRegs];           // Architectural registers, entry 0 stays zero
  dataT        modelMem [2 ** memAddrBits];
  regIdT       expRdQ [$];                    // One entry per issued instruction
  dataT        expDataQ [$];
  int          expEdgeQ [$];                  // Edge on which MEM/WB must hold it
  string       expNameQ [$];
  string       testName;
  regIdT       lastLoadRd;                    // Destination of a load issued last cycle
  logic [15:0] lfsrState = 16'd49;
  int          edgeCount = 0;
  int          checkCount = 0;
  int          errorCount = 0;

  pipeBackEnd #(.memAddrBits(memAddrBits)) DUT (
    .clk(clk), .rst(rst), .issueValid(issueValid), .issueOp(issueOp),
    .issueRs1(issueRs1), .issueRs2(issueRs2), .issueRd(issueRd), .issueImm(issueImm),
    .wbValid(wbValid), .wbRd(wbRd), .wbData(wbData)
  );

  initial begin
    forever #(clkPeriod / 2) clk = ~clk;
  end

  always @(posedge clk) edgeCount <= edgeCount + 1;

  // Watchdog sized from the instruction count
  initial begin
    #(clkPeriod * runCycles);
    $display("Timeout: the run did not finish within %0d clock cycles", runCycles);
    $display("Test failures found");
    $finish;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////////////////////////////////////////
  // 16-bit Fibonacci LFSR, taps 16 14 13 11
  function automatic logic [15:0] drawBits(input int n);
    logic [15:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsrState = {lfsrState[14:0], lfsrState[15] ^ lfsrState[13] ^ lfsrState[12] ^ lfsrState[10]};
      v = {v[14:0], lfsrState[0]};  // One step per bit taken
    end
    return v;
  endfunction

  // Small pool of ids so hazards come up often, register 0 about one time in eight
  function automatic regIdT pickReg();
    logic [15:0] r;
    r = drawBits(3);
    if (r == 16'd0) return '0;
    return regIdT'(r[1:0]) + regIdT'(1);
  endfunction

  function automatic dataT fillWord(input int addr);
    logic [7:0] a;
    a = addr[7:0];
    return {a ^ 8'h5A, ~a + 8'd3};  // Distinct for every address
  endfunction

  task automatic checkValue(input string what, input logic [31:0] expected,
                            input logic [31:0] actual);
    checkCount++;
    if (expected !== actual) begin
      errorCount++;
      $display("Error: %s expected %h actual %h", what, expected, actual);
    end
  endtask

  // Write-back must land exactly on the edge recorded at issue
  task automatic observeWriteback();
    string name;
    if (expEdgeQ.size() != 0 && expEdgeQ[0] == edgeCount) begin
      name = expNameQ.pop_front();
      void'(expEdgeQ.pop_front());
      if (wbValid !== 1'b1) begin
        errorCount++;
        $display("%s: no write-back two cycles after the issue edge", name);
        void'(expRdQ.pop_front());
        void'(expDataQ.pop_front());
      end else begin
        checkValue({name, " wbRd"}, 32'(expRdQ.pop_front()), 32'(wbRd));
        checkValue({name, " wbData"}, 32'(expDataQ.pop_front()), 32'(wbData));
      end
    end else if (wbValid !== 1'b0) begin
      errorCount++;
      $display("Write-back valid at cycle %0d with no instruction due", edgeCount);
    end
  endtask

  task automatic nextCycle();
    @(negedge clk);  // Outputs are stable here and inputs change here
    observeWriteback();
  endtask

  task automatic idleCycle();
    nextCycle();
    issueValid = 1'b0;
    lastLoadRd = '0;
  endtask

  // Executes the instruction in the model, then presents it to the DUT
  task automatic issueInstr(input aluOpT op, input regIdT rs1, input regIdT rs2,
                            input regIdT rd, input dataT imm);
    dataT a;
    dataT b;
    dataT res;
    a = modelRegs[rs1];
    b = modelRegs[rs2];
    case (op)
      opAdd:   res = a + b;
      opSub:   res = a - b;
      opAnd:   res = a & b;
      opXor:   res = a ^ b;
      opSll:   res = a << b[3:0];
      opSrl:   res = a >> b[3:0];
      opLoad: begin
        res = a + imm;
        res = modelMem[res[memAddrBits-1:0]];
      end
      default: begin
        res = a + imm;  // A store reports its address on wbData
        modelMem[res[memAddrBits-1:0]] = b;
      end
    endcase
    if (op != opStore && rd != '0) modelRegs[rd] = res;
    nextCycle();
    issueValid = 1'b1;
    issueOp    = op;
    issueRs1   = rs1;
    issueRs2   = rs2;
    issueRd    = rd;
    issueImm   = imm;
    expRdQ.push_back(rd);
    expDataQ.push_back(res);
    expEdgeQ.push_back(edgeCount + 3);  // Sampled next edge, in MEM/WB two edges later
    expNameQ.push_back(testName);
    lastLoadRd = (op == opLoad) ? rd : '0;
  endtask

  // Memory op whose immediate makes the address land on target
  task automatic issueMem(input aluOpT op, input regIdT rs1, input regIdT rs2,
                          input regIdT rd, input logic [7:0] target);
    issueInstr(op, rs1, rs2, rd, {8'h00, target} - modelRegs[rs1]);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////
  initial begin
    aluOpT       op;
    regIdT       rs1;
    regIdT       rs2;
    regIdT       rd;
    logic [15:0] bits;
    rst        = 1'b1;
    issueValid = 1'b0;
    issueOp    = opAdd;
    issueRs1   = '0;
    issueRs2   = '0;
    issueRd    = '0;
    issueImm   = '0;
    lastLoadRd = '0;
    foreach (modelRegs[i]) modelRegs[i] = '0;
    for (int i = 0; i < 2 ** memAddrBits; i++) begin
      modelMem[i] = fillWord(i);
      DUT.uMemoryStage.mem[i] = fillWord(i);  // Loads are the only way to get data in
    end
    repeat (resetCycles) @(negedge clk);
    rst = 1'b0;

    testName = "ex forwarding";
    issueMem(opLoad, 0, 0, 1, 8'h10);
    issueMem(opLoad, 0, 0, 2, 8'h11);
    idleCycle();                       // r2 is not used right behind its load
    issueInstr(opAdd, 1, 2, 3, '0);
    issueInstr(opSub, 3, 1, 4, '0);   // r3 one ahead
    issueInstr(opXor, 4, 3, 5, '0);   // r4 one ahead, r3 two ahead

    testName = "mem forwarding";
    issueInstr(opAdd, 1, 2, 6, '0);
    issueInstr(opAnd, 2, 1, 7, '0);
    issueInstr(opSll, 6, 2, 8, '0);
    issueInstr(opAdd, 1, 2, 9, '0);
    issueInstr(opAdd, 9, 1, 9, '0);
    issueInstr(opSrl, 9, 2, 10, '0);  // Both stages hold r9, newer must win

    testName = "store forwarding";
    issueMem(opLoad, 0, 0, 11, 8'h20);
    issueInstr(opXor, 1, 2, 12, '0);
    issueMem(opStore, 0, 11, 0, 8'h30);  // Load data two ahead
    issueInstr(opAdd, 11, 12, 13, '0);
    issueMem(opStore, 0, 13, 0, 8'h31);  // ALU writer one ahead
    issueMem(opLoad, 0, 0, 14, 8'h30);
    issueMem(opLoad, 0, 0, 15, 8'h31);

    testName = "register zero";
    issueInstr(opAdd, 1, 2, 0, '0);
    issueInstr(opAdd, 0, 1, 5, '0);
    issueInstr(opXor, 2, 0, 6, '0);
    issueMem(opLoad, 0, 0, 0, 8'h12);
    idleCycle();
    issueInstr(opSub, 0, 0, 7, '0);

    testName = "random";
    for (int n = 0; n < numRandom; n++) begin
      bits = drawBits(3);
      op   = aluOpT'(bits[2:0]);
      rs1  = pickReg();
      rs2  = pickReg();
      rd   = pickReg();
      bits = drawBits(3);
      // Keep consumers off the cycle right behind a load of their source
      if (bits == 16'd0 || (lastLoadRd != '0 && (rs1 == lastLoadRd || rs2 == lastLoadRd)))
        idleCycle();
      bits = drawBits(3);
      if (op == opLoad || op == opStore) issueMem(op, rs1, rs2, rd, 8'h40 | {5'd0, bits[2:0]});
      else issueInstr(op, rs1, rs2, rd, drawBits(16));
    end

    while (expEdgeQ.size() != 0) idleCycle();
    repeat (3) idleCycle();           // Catch any stray write-back

    $display("Checks: %0d, errors: %0d", checkCount, errorCount);
    if (errorCount == 0) $display("All tests passed!");
    else $display("Test failures found");
    $finish;
  end

endmodule : pipeBackEndTb

`default_nettype wire

/* compile.f */
hdl/pipePkg.sv
hdl/stageBus.sv
hdl/regFile.sv
hdl/forwardingUnit.sv
hdl/executeStage.sv
hdl/memoryStage.sv
hdl/pipeBackEnd.sv
tb/forwardChecker_checker.sv
tb/pipeBackEndTb.sv

/* Makefile */
TOP := pipeBackEndTb

.PHONY: all lint clean

all:
	verilator --binary --timing --assert --timescale 1ns/1ps -f compile.f --top-module $(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -q "Test failures found" sim.log; then \
	  echo "Simulation failed"; exit 1; \
	elif ! grep -q "All tests passed!" sim.log; then \
	  echo "Simulation ended early"; exit 1; \
	else \
	  echo "Simulation passed"; \
	fi

lint:
	verilator --lint-only --timing --timescale 1ns/1ps -f compile.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log
